// File: logic/dataMemory.sv
`timescale 1ns/100ps

module dataMemory
    import spiPkg::*;
(
    input  logic                 clk,
    input  ctrlStrobes           strobes,
    input  logic [dataWidth-1:0] busIn,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] mem [memDepth];
    logic [addrWidth-1:0] addrReg;
    logic [addrWidth-1:0] busAddr;
    logic [addrWidth-1:0] readAddr;

    // The address sits above the read/write bit in the first byte.
    assign busAddr = busIn[dataWidth-1 -: addrWidth];

    // Reading through the incoming address has the byte ready the cycle after the latch.
    assign readAddr = strobes.addrLatch ? busAddr : addrReg;

    always_ff @(posedge clk) begin
        if (strobes.addrLatch) begin
            addrReg <= busAddr;
        end
        if (strobes.memWrite) begin
            mem[addrReg] <= busIn;
        end
        readData <= mem[readAddr];
    end

endmodule

// File: logic/inputConditioner.sv
`timescale 1ns/100ps

module inputConditioner
    import spiPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   sclk,
    input  logic   csN,
    input  logic   mosi,
    output spiPins pins
);

    logic [rawPinCount-1:0]   rawPins;
    logic [rawPinCount-1:0]   syncStage1;
    logic [rawPinCount-1:0]   syncStage2;
    logic [rawPinCount-1:0]   stablePins;
    logic [debounceWidth-1:0] stableCount [rawPinCount];
    logic                     sclkPrev;

    assign rawPins = {mosi, csN, sclk};

    // Two-flop synchronizer on every pin.
    always_ff @(posedge clk) begin
        if (reset) begin
            syncStage1 <= rawPinsIdle;
            syncStage2 <= rawPinsIdle;
        end else begin
            syncStage1 <= rawPins;
            syncStage2 <= syncStage1;
        end
    end

    // A pin's conditioned level follows only after the synchronized level has
    // disagreed with it for debounceCycles cycles in a row.
    always_ff @(posedge clk) begin
        if (reset) begin
            stablePins <= rawPinsIdle;
            for (int i = 0; i < rawPinCount; i++) begin
                stableCount[i] <= '0;
            end
        end else begin
            for (int i = 0; i < rawPinCount; i++) begin
                if (syncStage2[i] == stablePins[i]) begin
                    stableCount[i] <= '0;
                end else if (stableCount[i] == debounceWidth'(debounceCycles - 1)) begin
                    stablePins[i] <= syncStage2[i];
                    stableCount[i] <= '0;
                end else begin
                    stableCount[i] <= stableCount[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sclkPrev <= 1'b0;
        end else begin
            sclkPrev <= stablePins[0];
        end
    end

    // Edge pulses last exactly one clk cycle.
    assign pins.sclkRise = stablePins[0] & ~sclkPrev;
    assign pins.sclkFall = ~stablePins[0] & sclkPrev;
    assign pins.csN = stablePins[1];
    assign pins.mosi = stablePins[2];

endmodule

// File: logic/shiftRegister.sv
`timescale 1ns/100ps

module shiftRegister
    import spiPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  spiPins               pins,
    input  ctrlStrobes           strobes,
    input  logic [dataWidth-1:0] parallelIn,
    output logic [dataWidth-1:0] parallelOut,
    output logic                 miso
);

    logic [dataWidth-1:0] shiftReg;

    // A parallel load from memory wins over a serial shift.
    always_ff @(posedge clk) begin
        if (strobes.shiftLoad) begin
            shiftReg <= parallelIn;
        end else if (pins.sclkRise) begin
            shiftReg <= {shiftReg[dataWidth-2:0], pins.mosi};
        end
    end

    // MISO changes on the falling serial edge so the master can sample it
    // on the following rising edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            miso <= 1'b0;
        end else if (pins.sclkFall) begin
            miso <= shiftReg[dataWidth-1];
        end
    end

    assign parallelOut = shiftReg;

endmodule

// File: logic/spiController.sv
`timescale 1ns/100ps

module spiController
    import spiPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  spiPins     pins,
    input  logic       rwBit,
    output ctrlStrobes strobes
);

    logic [stateWidth-1:0]    state;
    logic [bitCountWidth-1:0] bitCount;

    always_ff @(posedge clk) begin
        // Chip select going high aborts whatever is in progress.
        if (reset || pins.csN) begin
            state <= stateIdle;
            bitCount <= '0;
            strobes <= '0;
        end else begin
            strobes.addrLatch <= 1'b0;
            strobes.shiftLoad <= 1'b0;
            strobes.memWrite <= 1'b0;

            case (state)
                stateIdle: begin
                    state <= stateAddressLoad;
                    bitCount <= '0;
                end

                // Seven address bits and the read/write bit make eight rising edges.
                stateAddressLoad: begin
                    if (pins.sclkRise) begin
                        if (bitCount == bitCountWidth'(addrWidth)) begin
                            bitCount <= '0;
                            state <= stateBranch;
                            strobes.addrLatch <= 1'b1;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end

                // The read/write bit now sits in the shift register's LSB.
                stateBranch: begin
                    if (rwBit) begin
                        state <= stateDataLoad;
                        strobes.shiftLoad <= 1'b1;
                    end else begin
                        state <= stateWrite;
                    end
                end

                stateDataLoad: begin
                    state <= stateRead;
                end

                // The first falling edge puts the MSB on MISO; the ninth ends the read.
                stateRead: begin
                    if (pins.sclkFall) begin
                        if (bitCount == bitCountWidth'(dataWidth)) begin
                            strobes.misoEnable <= 1'b0;
                            bitCount <= '0;
                            state <= stateIdle;
                        end else begin
                            strobes.misoEnable <= 1'b1;
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end

                stateWrite: begin
                    if (pins.sclkRise) begin
                        if (bitCount == bitCountWidth'(dataWidth - 1)) begin
                            strobes.memWrite <= 1'b1;
                            bitCount <= '0;
                            state <= stateIdle;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= stateIdle;
                    bitCount <= '0;
                    strobes.misoEnable <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: logic/spiMemory.sv
`timescale 1ns/100ps

module spiMemory
    import spiPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso,
    output logic misoEnable
);

    spiPins               pins;
    ctrlStrobes           strobes;
    logic [dataWidth-1:0] parallelOut;
    logic [dataWidth-1:0] readData;
    logic                 rwBit;

    inputConditioner i_inputConditioner (
        .clk   (clk),
        .reset (reset),
        .sclk  (sclk),
        .csN   (csN),
        .mosi  (mosi),
        .pins  (pins)
    );

    // After the eighth bit the read/write flag is the newest bit shifted in.
    assign rwBit = parallelOut[0];

    spiController i_spiController (
        .clk     (clk),
        .reset   (reset),
        .pins    (pins),
        .rwBit   (rwBit),
        .strobes (strobes)
    );

    shiftRegister i_shiftRegister (
        .clk         (clk),
        .reset       (reset),
        .pins        (pins),
        .strobes     (strobes),
        .parallelIn  (readData),
        .parallelOut (parallelOut),
        .miso        (miso)
    );

    dataMemory i_dataMemory (
        .clk      (clk),
        .strobes  (strobes),
        .busIn    (parallelOut),
        .readData (readData)
    );

    assign misoEnable = strobes.misoEnable;

endmodule

// File: logic/spiPkg.sv
package spiPkg;

    // Each transaction carries a 7-bit address, a read/write bit and a data byte.
    localparam int addrWidth = 7;
    localparam int dataWidth = 8;
    localparam int memDepth = 128;

    // A pin must hold a new level this many clk cycles before it is accepted.
    localparam int debounceCycles = 3;
    localparam int debounceWidth = $clog2(debounceCycles);

    // The bit counter has to reach dataWidth in the read phase.
    localparam int bitCountWidth = $clog2(dataWidth + 1);

    // Raw pin order is {mosi, csN, sclk}; the bus idles with chip select high.
    localparam int rawPinCount = 3;
    localparam logic [rawPinCount-1:0] rawPinsIdle = 3'b010;

    // Controller state codes.
    localparam int stateWidth = 3;
    localparam logic [stateWidth-1:0] stateIdle = 3'd0;
    localparam logic [stateWidth-1:0] stateAddressLoad = 3'd1;
    localparam logic [stateWidth-1:0] stateBranch = 3'd2;
    localparam logic [stateWidth-1:0] stateDataLoad = 3'd3;
    localparam logic [stateWidth-1:0] stateRead = 3'd4;
    localparam logic [stateWidth-1:0] stateWrite = 3'd5;

    // Conditioned view of the SPI pins.
    typedef struct packed {
        logic sclkRise;
        logic sclkFall;
        logic csN;
        logic mosi;
    } spiPins;

    // Strobes from the controller to the datapath.
    typedef struct packed {
        logic addrLatch;
        logic shiftLoad;
        logic memWrite;
        logic misoEnable;
    } ctrlStrobes;

endpackage

// File: run.sh
#!/bin/sh
# Builds the SPI memory testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module spiMemoryTb \
    -f sources.f \
    --Mdir obj_dir \
    -o spiMemorySim

output=$(./obj_dir/spiMemorySim)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

// File: sources.f
logic/spiPkg.sv
logic/inputConditioner.sv
logic/shiftRegister.sv
logic/spiController.sv
logic/dataMemory.sv
logic/spiMemory.sv
verif/spiMemoryTb.sv

// File: verif/spiCases.txt
# op addr data abort glitch
# op is W or R, addr (7 bits) and data are hex, abort and glitch are 0 or 1
W 05 a5 0 0
R 05 a5 0 0
W 00 3c 0 0
W 7f c3 0 0
W 2a 5a 0 0
W 55 81 0 0
R 00 3c 0 0
R 7f c3 0 0
R 2a 5a 0 0
R 55 81 0 0
R 05 a5 0 0
W 05 0f 0 0
R 05 0f 0 0
R 2a 5a 0 0
W 2a ff 1 0
R 2a 5a 0 0
W 00 e7 1 0
R 00 3c 0 0
R 7f c3 1 0
R 7f c3 0 0
W 11 96 0 1
R 11 96 0 0
W 12 69 0 0
R 12 69 0 1
R 11 96 0 1
W 10 24 0 1
R 10 24 0 0
R 11 96 0 0
W 01 80 0 0
R 01 80 0 0

// File: verif/spiMemoryTb.sv
`timescale 1ns/100ps

module spiMemoryTb
    import spiPkg::*;
();

    // Every SPI clock phase lasts this many clk cycles.
    localparam int phaseClk = 20;
    localparam int glitchClk = 2;
    localparam int glitchBit = 3;
    localparam int abortBits = 12;
    localparam int frameBits = addrWidth + 1 + dataWidth;
    localparam int caseOverheadClk = 200;
    localparam int startupClk = 500;

    typedef struct packed {
        logic                 isRead;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        logic                 abort;
        logic                 glitch;
    } spiCase;

    logic clk = 1'b0;
    logic reset;
    logic sclk;
    logic csN;
    logic mosi;
    logic miso;
    logic misoEnable;

    spiCase               cases[$];
    logic [dataWidth-1:0] refMem [memDepth];
    bit                   refValid [memDepth];
    int                   errorCount = 0;
    int                   passCount = 0;
    int                   failCount = 0;
    bit                   casesLoaded = 1'b0;

    always #5 clk = ~clk;

    spiMemory i_spiMemory (
        .clk        (clk),
        .reset      (reset),
        .sclk       (sclk),
        .csN        (csN),
        .mosi       (mosi),
        .miso       (miso),
        .misoEnable (misoEnable)
    );

    task automatic expectByte(input string sigName, input logic [dataWidth-1:0] got,
                              input logic [dataWidth-1:0] expected);
        assert (got === expected) else begin
            $display("FAILED %s: got %h, expected %h", sigName, got, expected);
            errorCount++;
        end
    endtask

    task automatic expectBit(input string sigName, input logic got, input logic expected);
        assert (got === expected) else begin
            $display("FAILED %s: got %h, expected %h", sigName, got, expected);
            errorCount++;
        end
    endtask

    task automatic loadCases();
        int                   fd;
        int                   fields;
        string                line;
        byte                  opChar;
        logic [addrWidth-1:0] addrVal;
        logic [dataWidth-1:0] dataVal;
        int                   abortVal;
        int                   glitchVal;
        spiCase               tc;
        fd = $fopen("verif/spiCases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open verif/spiCases.txt for reading");
            errorCount++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%c %h %h %d %d", opChar, addrVal, dataVal,
                                 abortVal, glitchVal);
                assert (fields == 5 && (opChar == "R" || opChar == "W")) else begin
                    $display("Cases file holds a line that cannot be parsed: %s", line);
                    errorCount++;
                end
                if (fields == 5) begin
                    tc.isRead = (opChar == "R");
                    tc.addr = addrVal;
                    tc.data = dataVal;
                    tc.abort = (abortVal != 0);
                    tc.glitch = (glitchVal != 0);
                    cases.push_back(tc);
                end
            end
            $fclose(fd);
        end
    endtask

    // One serial bit in mode 0. MOSI is set while sclk is low, and MISO is
    // sampled mid-cycle just before the rising edge.
    task automatic shiftBit(input logic txBit, input bit glitch,
                            output logic rxBit, output logic rxEnable);
        @(posedge clk);
        mosi <= txBit;
        if (glitch) begin
            repeat (5) @(posedge clk);
            sclk <= 1'b1;
            repeat (glitchClk) @(posedge clk);
            sclk <= 1'b0;
            repeat (phaseClk - 7 - glitchClk) @(posedge clk);
        end else begin
            repeat (phaseClk - 2) @(posedge clk);
        end
        @(negedge clk);
        rxBit = miso;
        rxEnable = misoEnable;
        @(posedge clk);
        sclk <= 1'b1;
        repeat (phaseClk) @(posedge clk);
        sclk <= 1'b0;
    endtask

    task automatic runTransaction(input spiCase tc, output logic [dataWidth-1:0] rxByte);
        logic [frameBits-1:0] frame;
        logic                 rxBit;
        logic                 rxEnable;
        int                   bitsToSend;
        frame = {tc.addr, tc.isRead, tc.isRead ? {dataWidth{1'b0}} : tc.data};
        bitsToSend = tc.abort ? abortBits : frameBits;
        rxByte = '0;
        @(posedge clk);
        csN <= 1'b0;
        repeat (phaseClk) @(posedge clk);
        for (int i = 0; i < bitsToSend; i++) begin
            shiftBit(frame[frameBits-1-i], tc.glitch && (i == glitchBit), rxBit, rxEnable);
            // Read data shows up before rising edges 9 through 16.
            if (i > addrWidth) begin
                rxByte = {rxByte[dataWidth-2:0], rxBit};
                expectBit("misoEnable", rxEnable, tc.isRead);
            end else begin
                expectBit("misoEnable", rxEnable, 1'b0);
            end
        end
        repeat (phaseClk - 1) @(posedge clk);
        @(negedge clk);
        if (!tc.abort) begin
            expectBit("misoEnable", misoEnable, 1'b0);
        end
        @(posedge clk);
        csN <= 1'b1;
        repeat (2 * phaseClk) @(posedge clk);
        @(negedge clk);
        expectBit("misoEnable", misoEnable, 1'b0);
    endtask

    task automatic checkModel(input spiCase tc);
        assert (refValid[tc.addr]) else begin
            $display("Read of address %h comes before any write to it", tc.addr);
            errorCount++;
        end
        assert (!refValid[tc.addr] || refMem[tc.addr] === tc.data) else begin
            $display("Cases file expects %h at address %h but the model holds %h",
                     tc.data, tc.addr, refMem[tc.addr]);
            errorCount++;
        end
    endtask

    function automatic string describeCase(input spiCase tc);
        return $sformatf("%s addr %h data %h%s%s", tc.isRead ? "read " : "write",
                         tc.addr, tc.data, tc.abort ? " aborted" : "",
                         tc.glitch ? " with sclk glitch" : "");
    endfunction

    task automatic reportTest(input int testIndex, input string label, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %0d %s: passed", testIndex, label);
        end else begin
            failCount++;
            $display("test %0d %s: failed", testIndex, label);
        end
    endtask

    initial begin
        spiCase               tc;
        logic [dataWidth-1:0] rxByte;
        int                   errorsBefore;
        reset = 1'b1;
        sclk = 1'b0;
        csN = 1'b1;
        mosi = 1'b0;
        loadCases();
        casesLoaded = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (phaseClk) @(posedge clk);

        @(negedge clk);
        errorsBefore = errorCount;
        expectBit("misoEnable", misoEnable, 1'b0);
        expectBit("miso", miso, 1'b0);
        reportTest(0, "idle after reset", errorsBefore);

        foreach (cases[n]) begin
            tc = cases[n];
            errorsBefore = errorCount;
            runTransaction(tc, rxByte);
            if (tc.isRead && !tc.abort) begin
                checkModel(tc);
                expectByte("miso", rxByte, tc.data);
            end
            // An aborted write must leave the memory as it was.
            if (!tc.isRead && !tc.abort) begin
                refMem[tc.addr] = tc.data;
                refValid[tc.addr] = 1'b1;
            end
            reportTest(n + 1, describeCase(tc), errorsBefore);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 passCount + failCount, passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Each case takes 16 bits of two phases plus chip select setup and hold.
    initial begin
        int limitClk;
        wait (casesLoaded);
        limitClk = cases.size() * (frameBits * 2 * phaseClk + caseOverheadClk) + startupClk;
        repeat (limitClk) @(posedge clk);
        $display("Timeout: the transactions did not finish within %0d clk cycles", limitClk);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
